// File: hw/rvh_pkg.sv
package rvh_pkg;

    // register index width
    parameter int unsigned REG_ADDR_W = 5;

    // instruction word width
    parameter int unsigned INST_W = 32;

    // offset bits kept for the store-to-load address match
    parameter int unsigned IMM_W = 12;

    // program counter width
    parameter int unsigned XLEN = 64;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    // coarse instruction class seen by the hazard logic
    typedef enum logic [2:0] {
        CLS_ALU    = 3'd0,
        CLS_LOAD   = 3'd1,
        CLS_STORE  = 3'd2,
        CLS_BRANCH = 3'd3,
        CLS_NONE   = 3'd4
    } inst_class_e;

    // stall reasons, listed in priority order
    typedef enum logic [1:0] {
        STALL_NONE       = 2'd0,
        STALL_RAW_EX     = 2'd1,
        STALL_RAW_MEM    = 2'd2,
        STALL_STORE_LOAD = 2'd3
    } stall_cause_e;

endpackage

// File: hw/id_decode.sv
`timescale 1ns/1ps

module id_decode (
    input  logic [rvh_pkg::INST_W-1:0]     id_inst,
    output logic [rvh_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rvh_pkg::REG_ADDR_W-1:0] rs2,
    output logic                           rs1_used,
    output logic                           rs2_used,
    output logic [rvh_pkg::REG_ADDR_W-1:0] rd,
    output logic                           rd_we,
    output logic [rvh_pkg::IMM_W-1:0]      offset,
    output rvh_pkg::inst_class_e           inst_class
);

    rvh_pkg::opcode_e opcode;
    logic             writes_rd;

    assign opcode = rvh_pkg::opcode_e'(id_inst[6:0]);

    // register fields sit at fixed positions in every format
    assign rs1 = id_inst[19:15];
    assign rs2 = id_inst[24:20];
    assign rd  = id_inst[11:7];

    // x0 is never a real destination
    assign rd_we = writes_rd && (rd != '0);

    // S offset for stores, I offset for everything else
    assign offset = (opcode == rvh_pkg::OP_STORE) ? {id_inst[31:25], id_inst[11:7]}
                                                  : id_inst[31:20];

    always_comb begin
        rs1_used   = 1'b0;
        rs2_used   = 1'b0;
        writes_rd  = 1'b0;
        inst_class = rvh_pkg::CLS_NONE;
        case (opcode)
            rvh_pkg::OP_LOAD: begin
                rs1_used   = 1'b1;
                writes_rd  = 1'b1;
                inst_class = rvh_pkg::CLS_LOAD;
            end
            rvh_pkg::OP_STORE: begin
                rs1_used   = 1'b1;
                rs2_used   = 1'b1;
                inst_class = rvh_pkg::CLS_STORE;
            end
            rvh_pkg::OP_IMM,
            rvh_pkg::OP_JALR: begin
                rs1_used   = 1'b1;
                writes_rd  = 1'b1;
                inst_class = rvh_pkg::CLS_ALU;
            end
            rvh_pkg::OP_REG: begin
                rs1_used   = 1'b1;
                rs2_used   = 1'b1;
                writes_rd  = 1'b1;
                inst_class = rvh_pkg::CLS_ALU;
            end
            rvh_pkg::OP_BRANCH: begin
                rs1_used   = 1'b1;
                rs2_used   = 1'b1;
                inst_class = rvh_pkg::CLS_BRANCH;
            end
            // lui and jal read no registers
            rvh_pkg::OP_LUI,
            rvh_pkg::OP_JAL: begin
                writes_rd  = 1'b1;
                inst_class = rvh_pkg::CLS_ALU;
            end
            default: begin
                // unknown opcode, treated as a nop
                inst_class = rvh_pkg::CLS_NONE;
            end
        endcase
    end

endmodule

// File: hw/inflight_track.sv
`timescale 1ns/1ps

module inflight_track (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           id_valid,
    input  logic                           stall_id,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] rd,
    input  logic                           rd_we,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rvh_pkg::IMM_W-1:0]      offset,
    input  rvh_pkg::inst_class_e           inst_class,
    output logic [rvh_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                           ex_rd_we,
    output rvh_pkg::inst_class_e           ex_class,
    output logic [rvh_pkg::REG_ADDR_W-1:0] ex_rs1,
    output logic [rvh_pkg::IMM_W-1:0]      ex_offset,
    output logic [rvh_pkg::REG_ADDR_W-1:0] mem_rd,
    output logic                           mem_rd_we
);

    logic issue;

    // ID moves to EX only when valid and not held
    assign issue = id_valid && !stall_id;

    // control state, a bubble after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rd_we  <= 1'b0;
            ex_class  <= rvh_pkg::CLS_NONE;
            mem_rd_we <= 1'b0;
        end else begin
            if (issue) begin
                ex_rd_we <= rd_we;
                ex_class <= inst_class;
            end else begin
                ex_rd_we <= 1'b0;
                ex_class <= rvh_pkg::CLS_NONE;
            end
            // MEM always follows EX
            mem_rd_we <= ex_rd_we;
        end
    end

    // payload fields
    // only meaningful when the matching control bits say so
    always_ff @(posedge clk) begin
        ex_rd     <= rd;
        ex_rs1    <= rs1;
        ex_offset <= offset;
        mem_rd    <= ex_rd;
    end

    // decode must never hand a write to x0 down the pipe
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_rd_we |-> (ex_rd != '0)
    ) else $error("EX stage marks a write to x0");

endmodule

// File: hw/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           id_valid,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] rs2,
    input  logic                           rs1_used,
    input  logic                           rs2_used,
    input  rvh_pkg::inst_class_e           inst_class,
    input  logic [rvh_pkg::IMM_W-1:0]      offset,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                           ex_rd_we,
    input  rvh_pkg::inst_class_e           ex_class,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [rvh_pkg::IMM_W-1:0]      ex_offset,
    input  logic [rvh_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                           mem_rd_we,
    output rvh_pkg::stall_cause_e          cause
);

    logic rs1_hit_ex;
    logic rs2_hit_ex;
    logic rs1_hit_mem;
    logic rs2_hit_mem;
    logic raw_ex;
    logic raw_mem;
    logic store_load;

    // source matches against the EX destination
    assign rs1_hit_ex = rs1_used && (rs1 == ex_rd);
    assign rs2_hit_ex = rs2_used && (rs2 == ex_rd);
    assign raw_ex     = ex_rd_we && (rs1_hit_ex || rs2_hit_ex);

    // same against MEM
    assign rs1_hit_mem = rs1_used && (rs1 == mem_rd);
    assign rs2_hit_mem = rs2_used && (rs2 == mem_rd);
    assign raw_mem     = mem_rd_we && (rs1_hit_mem || rs2_hit_mem);

    // Conservative address match: same base register index and same
    // 12-bit offset. Register contents are not known here.
    assign store_load = (inst_class == rvh_pkg::CLS_LOAD)
                     && (ex_class == rvh_pkg::CLS_STORE)
                     && (rs1 == ex_rs1)
                     && (offset == ex_offset);

    always_comb begin
        if (!id_valid) begin
            cause = rvh_pkg::STALL_NONE;
        end else if (raw_ex) begin
            cause = rvh_pkg::STALL_RAW_EX;
        end else if (raw_mem) begin
            cause = rvh_pkg::STALL_RAW_MEM;
        end else if (store_load) begin
            cause = rvh_pkg::STALL_STORE_LOAD;
        end else begin
            cause = rvh_pkg::STALL_NONE;
        end
    end

    a_cause_legal : assert property (
        @(posedge clk) disable iff (!rst_n)
        cause inside {rvh_pkg::STALL_NONE, rvh_pkg::STALL_RAW_EX,
                      rvh_pkg::STALL_RAW_MEM, rvh_pkg::STALL_STORE_LOAD}
    ) else $error("illegal stall cause %0h", cause);

    // the tracker must really hold a store when this cause fires
    a_store_in_ex : assert property (
        @(posedge clk) disable iff (!rst_n)
        (cause == rvh_pkg::STALL_STORE_LOAD) |-> (ex_class == rvh_pkg::CLS_STORE)
    ) else $error("store-to-load stall without a store in EX");

endmodule

// File: hw/stall_ctrl.sv
`timescale 1ns/1ps

module stall_ctrl #(
    parameter int unsigned CNT_W = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rvh_pkg::stall_cause_e cause,
    input  logic                  cnt_clr,
    output logic                  stall_id,
    output rvh_pkg::stall_cause_e stall_cause,
    output logic [CNT_W-1:0]      cnt_raw_ex,
    output logic [CNT_W-1:0]      cnt_raw_mem,
    output logic [CNT_W-1:0]      cnt_store_load
);

    // combinational hold request for the ID driver
    assign stall_id    = (cause != rvh_pkg::STALL_NONE);
    assign stall_cause = cause;

    // per-cause stall counters, saturating at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_raw_ex     <= '0;
            cnt_raw_mem    <= '0;
            cnt_store_load <= '0;
        end else if (cnt_clr) begin
            cnt_raw_ex     <= '0;
            cnt_raw_mem    <= '0;
            cnt_store_load <= '0;
        end else begin
            case (cause)
                rvh_pkg::STALL_RAW_EX: begin
                    if (cnt_raw_ex != '1)
                        cnt_raw_ex <= cnt_raw_ex + 1'b1;
                end
                rvh_pkg::STALL_RAW_MEM: begin
                    if (cnt_raw_mem != '1)
                        cnt_raw_mem <= cnt_raw_mem + 1'b1;
                end
                rvh_pkg::STALL_STORE_LOAD: begin
                    if (cnt_store_load != '1)
                        cnt_store_load <= cnt_store_load + 1'b1;
                end
                default: begin
                    // no stall this cycle
                end
            endcase
        end
    end

    a_raw_ex_sat : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((cnt_raw_ex == '1) && !cnt_clr) |=> (cnt_raw_ex != '0)
    ) else $error("cnt_raw_ex wrapped");

    a_raw_mem_sat : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((cnt_raw_mem == '1) && !cnt_clr) |=> (cnt_raw_mem != '0)
    ) else $error("cnt_raw_mem wrapped");

    a_store_load_sat : assert property (
        @(posedge clk) disable iff (!rst_n)
        ((cnt_store_load == '1) && !cnt_clr) |=> (cnt_store_load != '0)
    ) else $error("cnt_store_load wrapped");

endmodule

// File: hw/hazard_unit_top.sv
`timescale 1ns/1ps

module hazard_unit_top #(
    parameter int unsigned CNT_W = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        id_valid,
    input  logic [rvh_pkg::INST_W-1:0]  id_inst,
    // id_pc is not used by the hazard logic
    // it only lets the ID driver log a stall against its PC
    input  logic [rvh_pkg::XLEN-1:0]    id_pc,
    input  logic                        cnt_clr,
    output logic                        stall_id,
    output rvh_pkg::stall_cause_e       stall_cause,
    output logic [CNT_W-1:0]            cnt_raw_ex,
    output logic [CNT_W-1:0]            cnt_raw_mem,
    output logic [CNT_W-1:0]            cnt_store_load
);

    // decoded ID fields
    logic [rvh_pkg::REG_ADDR_W-1:0] rs1;
    logic [rvh_pkg::REG_ADDR_W-1:0] rs2;
    logic                           rs1_used;
    logic                           rs2_used;
    logic [rvh_pkg::REG_ADDR_W-1:0] rd;
    logic                           rd_we;
    logic [rvh_pkg::IMM_W-1:0]      offset;
    rvh_pkg::inst_class_e           inst_class;

    // EX and MEM shadows
    logic [rvh_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                           ex_rd_we;
    rvh_pkg::inst_class_e           ex_class;
    logic [rvh_pkg::REG_ADDR_W-1:0] ex_rs1;
    logic [rvh_pkg::IMM_W-1:0]      ex_offset;
    logic [rvh_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                           mem_rd_we;

    rvh_pkg::stall_cause_e          cause;

    id_decode i_id_decode (
        .id_inst    (id_inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_used   (rs1_used),
        .rs2_used   (rs2_used),
        .rd         (rd),
        .rd_we      (rd_we),
        .offset     (offset),
        .inst_class (inst_class)
    );

    inflight_track i_inflight_track (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .stall_id   (stall_id),
        .rd         (rd),
        .rd_we      (rd_we),
        .rs1        (rs1),
        .offset     (offset),
        .inst_class (inst_class),
        .ex_rd      (ex_rd),
        .ex_rd_we   (ex_rd_we),
        .ex_class   (ex_class),
        .ex_rs1     (ex_rs1),
        .ex_offset  (ex_offset),
        .mem_rd     (mem_rd),
        .mem_rd_we  (mem_rd_we)
    );

    hazard_detect i_hazard_detect (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_used   (rs1_used),
        .rs2_used   (rs2_used),
        .inst_class (inst_class),
        .offset     (offset),
        .ex_rd      (ex_rd),
        .ex_rd_we   (ex_rd_we),
        .ex_class   (ex_class),
        .ex_rs1     (ex_rs1),
        .ex_offset  (ex_offset),
        .mem_rd     (mem_rd),
        .mem_rd_we  (mem_rd_we),
        .cause      (cause)
    );

    stall_ctrl #(
        .CNT_W (CNT_W)
    ) i_stall_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cause          (cause),
        .cnt_clr        (cnt_clr),
        .stall_id       (stall_id),
        .stall_cause    (stall_cause),
        .cnt_raw_ex     (cnt_raw_ex),
        .cnt_raw_mem    (cnt_raw_mem),
        .cnt_store_load (cnt_store_load)
    );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release reset just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: verification/tb_hazard_unit.sv
`timescale 1ns/1ps

module tb_hazard_unit;

    localparam int         CNT_W     = 16;
    localparam logic [6:0] OPC_LOAD  = 7'h03;
    localparam logic [6:0] OPC_STORE = 7'h23;
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_REG   = 7'h33;
    localparam logic [6:0] OPC_LUI   = 7'h37;

    logic                  clk;
    logic                  rst_n;
    logic                  id_valid;
    logic [31:0]           id_inst;
    logic [63:0]           id_pc;
    logic                  cnt_clr;
    logic                  stall_id;
    rvh_pkg::stall_cause_e stall_cause;
    logic [CNT_W-1:0]      cnt_raw_ex;
    logic [CNT_W-1:0]      cnt_raw_mem;
    logic [CNT_W-1:0]      cnt_store_load;

    // reference EX and MEM shadows
    logic [4:0]            m_ex_rd;
    logic                  m_ex_we;
    logic                  m_ex_store;
    logic [4:0]            m_ex_rs1;
    logic [11:0]           m_ex_off;
    logic [4:0]            m_mem_rd;
    logic                  m_mem_we;
    // model counters indexed by stall cause value
    logic [CNT_W-1:0]      m_cnt [4];
    rvh_pkg::stall_cause_e exp_cause;
    logic [2:0]            u;

    int                    errors;
    int                    n_ok;
    int                    n_bad;
    int                    cycles;
    int                    start;
    int                    stalls;
    logic [31:0]           rng;
    logic [31:0]           r;
    logic [4:0]            ra;
    logic [4:0]            rb;
    logic [4:0]            rc;
    logic [11:0]           ro;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hazard_unit_top #(
        .CNT_W (CNT_W)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .id_valid       (id_valid),
        .id_inst        (id_inst),
        .id_pc          (id_pc),
        .cnt_clr        (cnt_clr),
        .stall_id       (stall_id),
        .stall_cause    (stall_cause),
        .cnt_raw_ex     (cnt_raw_ex),
        .cnt_raw_mem    (cnt_raw_mem),
        .cnt_store_load (cnt_store_load)
    );

    // xorshift32 step on the shared state
    function automatic logic [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] enc_load(logic [4:0] rd, logic [4:0] rs1, logic [11:0] off);
        return {off, rs1, 3'b011, rd, OPC_LOAD};
    endfunction

    function automatic logic [31:0] enc_store(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b011, off[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_imm(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_reg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    // register fields an opcode really uses as {rs1, rs2, rd}
    function automatic logic [2:0] reg_use(input logic [6:0] opc);
        case (opc)
            OPC_LOAD, OPC_IMM, 7'h67: return 3'b101;
            OPC_STORE, 7'h63:         return 3'b110;
            OPC_REG:                  return 3'b111;
            OPC_LUI, 7'h6f:           return 3'b001;
            default:                  return 3'b000;
        endcase
    endfunction

    function automatic logic [11:0] mem_off(input logic [31:0] inst);
        if (inst[6:0] == OPC_STORE)
            return {inst[31:25], inst[11:7]};
        return inst[31:20];
    endfunction

    // expected cause from the shadows with the rules in priority order
    function automatic rvh_pkg::stall_cause_e ref_cause(input logic valid,
                                                        input logic [31:0] inst);
        logic [2:0] use_bits;
        logic       hit_ex;
        logic       hit_mem;
        logic       st_ld;
        use_bits = reg_use(inst[6:0]);
        hit_ex  = m_ex_we && ((use_bits[2] && inst[19:15] == m_ex_rd)
                           || (use_bits[1] && inst[24:20] == m_ex_rd));
        hit_mem = m_mem_we && ((use_bits[2] && inst[19:15] == m_mem_rd)
                            || (use_bits[1] && inst[24:20] == m_mem_rd));
        st_ld   = (inst[6:0] == OPC_LOAD) && m_ex_store && (inst[19:15] == m_ex_rs1)
                  && (mem_off(inst) == m_ex_off);
        if (!valid)
            return rvh_pkg::STALL_NONE;
        if (hit_ex)
            return rvh_pkg::STALL_RAW_EX;
        if (hit_mem)
            return rvh_pkg::STALL_RAW_MEM;
        if (st_ld)
            return rvh_pkg::STALL_STORE_LOAD;
        return rvh_pkg::STALL_NONE;
    endfunction

    // hold one instruction in ID until the unit takes it
    task automatic issue(input logic [31:0] inst, input int exp_stalls);
        logic held;
        id_valid = 1'b1;
        id_inst  = inst;
        stalls   = 0;
        held     = 1'b1;
        while (held) begin
            @(negedge clk);
            held = stall_id;
            if (held)
                stalls = stalls + 1;
            @(posedge clk);
            #1;
        end
        if (exp_stalls >= 0 && stalls != exp_stalls) begin
            $display("[ERROR] stall_id cycles for inst %h at pc %h expected %h got %h",
                     inst, id_pc, exp_stalls, stalls);
            errors = errors + 1;
        end
        id_pc = id_pc + 4;
    endtask

    task automatic idle(input int n);
        id_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_counters();
        @(negedge clk);
        if (cnt_raw_ex !== m_cnt[rvh_pkg::STALL_RAW_EX]) begin
            $display("[ERROR] cnt_raw_ex expected %h got %h",
                     m_cnt[rvh_pkg::STALL_RAW_EX], cnt_raw_ex);
            errors = errors + 1;
        end
        if (cnt_raw_mem !== m_cnt[rvh_pkg::STALL_RAW_MEM]) begin
            $display("[ERROR] cnt_raw_mem expected %h got %h",
                     m_cnt[rvh_pkg::STALL_RAW_MEM], cnt_raw_mem);
            errors = errors + 1;
        end
        if (cnt_store_load !== m_cnt[rvh_pkg::STALL_STORE_LOAD]) begin
            $display("[ERROR] cnt_store_load expected %h got %h",
                     m_cnt[rvh_pkg::STALL_STORE_LOAD], cnt_store_load);
            errors = errors + 1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int first_err);
        if (errors == first_err) begin
            n_ok = n_ok + 1;
            $display("test %s: ok", name);
        end else begin
            n_bad = n_bad + 1;
            $display("test %s: %0d errors", name, errors - first_err);
        end
    endtask

    // compare at the falling edge with inputs and outputs settled
    always @(negedge clk) begin
        if (rst_n) begin
            exp_cause = ref_cause(id_valid, id_inst);
            if (stall_id !== (exp_cause != rvh_pkg::STALL_NONE)) begin
                $display("[ERROR] stall_id expected %h got %h at cycle %0d",
                         exp_cause != rvh_pkg::STALL_NONE, stall_id, cycles);
                errors = errors + 1;
            end
            if (stall_cause !== exp_cause) begin
                $display("[ERROR] stall_cause expected %h got %h at cycle %0d",
                         exp_cause, stall_cause, cycles);
                errors = errors + 1;
            end
        end
    end

    // reference pipeline and counters
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_ex_we    = 1'b0;
            m_ex_store = 1'b0;
            m_mem_we   = 1'b0;
            foreach (m_cnt[k])
                m_cnt[k] = '0;
        end else begin
            if (cnt_clr) begin
                foreach (m_cnt[k])
                    m_cnt[k] = '0;
            end else if (exp_cause != rvh_pkg::STALL_NONE && m_cnt[exp_cause] != '1) begin
                m_cnt[exp_cause] = m_cnt[exp_cause] + 1'b1;
            end
            // MEM takes the old EX
            m_mem_we = m_ex_we;
            m_mem_rd = m_ex_rd;
            if (id_valid && exp_cause == rvh_pkg::STALL_NONE) begin
                u          = reg_use(id_inst[6:0]);
                m_ex_we    = u[0] && (id_inst[11:7] != 5'd0);
                m_ex_rd    = id_inst[11:7];
                m_ex_store = (id_inst[6:0] == OPC_STORE);
                m_ex_rs1   = id_inst[19:15];
                m_ex_off   = mem_off(id_inst);
            end else begin
                m_ex_we    = 1'b0;
                m_ex_store = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == 3000) begin
            $display("timeout: the run did not finish within 3000 cycles");
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        id_valid  = 1'b0;
        id_inst   = '0;
        id_pc     = 64'h8000_0000;
        cnt_clr   = 1'b0;
        errors    = 0;
        n_ok      = 0;
        n_bad     = 0;
        cycles    = 0;
        rng       = 32'hbbf7aa2f;
        exp_cause = rvh_pkg::STALL_NONE;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        start = errors;
        check_counters();
        for (int i = 1; i < 8; i++)
            issue(enc_imm(5'(i), 5'd0, 12'(i)), 0);
        issue(enc_lui(5'd3, 20'h12345), 0);
        issue(enc_reg(5'd4, 5'd0, 5'd0), 0);
        idle(2);
        check_counters();
        report_test("reset_and_independent", start);

        start = errors;
        issue(enc_imm(5'd5, 5'd0, 12'd7), 0);
        issue(enc_reg(5'd6, 5'd5, 5'd1), 2);
        idle(2);
        issue(enc_imm(5'd0, 5'd2, 12'd1), 0);
        issue(enc_reg(5'd6, 5'd0, 5'd3), 0);
        idle(2);
        // rs2 field of the addi is 5 but unused
        issue(enc_imm(5'd5, 5'd0, 12'd1), 0);
        issue(enc_imm(5'd6, 5'd1, 12'd5), 0);
        idle(2);
        check_counters();
        report_test("raw_ex_then_mem", start);

        start = errors;
        issue(enc_imm(5'd5, 5'd0, 12'd1), 0);
        issue(enc_imm(5'd1, 5'd2, 12'd3), 0);
        issue(enc_reg(5'd6, 5'd5, 5'd0), 1);
        idle(2);
        // store offset puts 5 in the rd field
        issue(enc_store(5'd3, 5'd2, 12'd5), 0);
        issue(enc_reg(5'd6, 5'd5, 5'd0), 0);
        issue(enc_reg(5'd7, 5'd5, 5'd0), 0);
        idle(2);
        check_counters();
        report_test("raw_mem_only", start);

        start = errors;
        issue(enc_store(5'd3, 5'd2, 12'd16), 0);
        issue(enc_load(5'd4, 5'd2, 12'd16), 1);
        idle(2);
        issue(enc_store(5'd3, 5'd2, 12'd16), 0);
        issue(enc_load(5'd4, 5'd2, 12'd24), 0);
        idle(2);
        issue(enc_store(5'd3, 5'd2, 12'd16), 0);
        issue(enc_load(5'd4, 5'd1, 12'd16), 0);
        idle(2);
        issue(enc_store(5'd2, 5'd2, 12'd8), 0);
        issue(enc_load(5'd2, 5'd2, 12'd8), 1);
        idle(2);
        check_counters();
        report_test("store_to_load", start);

        start = errors;
        check_counters();
        cnt_clr = 1'b1;
        @(posedge clk);
        #1;
        cnt_clr = 1'b0;
        check_counters();
        report_test("counter_clear", start);

        // dense conflicts over x0..x7 with four bases and two offsets
        start = errors;
        for (int n = 0; n < 1000; n++) begin
            r = rand_next();
            if (r[31:29] == 3'd0) begin
                id_valid = 1'b0;
                id_inst  = rand_next();
                @(posedge clk);
                #1;
            end
            ra = {2'b00, r[10:8]};
            rb = {3'b000, r[12:11]};
            rc = {2'b00, r[16:14]};
            ro = {8'd0, r[17], 3'd0};
            case (r[2:0])
                3'd0, 3'd1: issue(enc_load(ra, rb, ro), -1);
                3'd2, 3'd3: issue(enc_store(rc, rb, ro), -1);
                3'd4:       issue(enc_imm(ra, rc, ro), -1);
                3'd6:       issue(enc_lui(ra, r[31:12]), -1);
                default:    issue(enc_reg(ra, rb, rc), -1);
            endcase
        end
        idle(2);
        check_counters();
        report_test("random_mix", start);

        $display("tests ok: %0d, tests with errors: %0d, check errors: %0d",
                 n_ok, n_bad, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: hazard_unit_top.f
hw/rvh_pkg.sv
hw/id_decode.sv
hw/inflight_track.sv
hw/hazard_detect.sv
hw/stall_ctrl.sv
hw/hazard_unit_top.sv
verification/tb_clk_gen.sv
verification/tb_hazard_unit.sv

// File: Bender.yml
package:
  name: hazard_unit

sources:
  - hw/rvh_pkg.sv
  - hw/id_decode.sv
  - hw/inflight_track.sv
  - hw/hazard_detect.sv
  - hw/stall_ctrl.sv
  - hw/hazard_unit_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_hazard_unit.sv
